/* compile.f */
+incdir+src
src/ptp_pkg.sv
src/ptp_regs.sv
src/ptp_rtc.sv
src/ptp_trigger.sv
src/ptp_core.sv
tb/ptp_core_sva.sv
tb/tb_ptp_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_ptp_core -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_ptp_core)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "NO ERRORS"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* tb/tb_ptp_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_ptp_core;

    import ptp_pkg::*;

    `include "ptp_version.svh"

    localparam int unsigned NS_STEP     = 40;
    localparam int unsigned ACK_TIMEOUT = 16;

    logic        clk;
    logic        rst;
    up_wr_t      wr;
    up_rd_t      rd;
    logic        wr_ack;
    logic        rd_ack;
    logic [31:0] rd_data;
    logic        pps_in;
    logic        ext_trig;
    logic        trig_out;

    logic [31:0] lfsr        = 32'h9cd2;
    int unsigned cycle_count = 0;
    int unsigned trig_count  = 0;
    int unsigned errors      = 0;
    int unsigned checks      = 0;
    int unsigned tests       = 0;
    int unsigned mark        = 0;
    int unsigned sva_fails;
    bit          timed_out   = 1'b0;

    ptp_core #(
        .ADDR_WIDTH (10),
        .NS_STEP    (NS_STEP)
    ) u_ptp_core (
        .clk      (clk),
        .rst      (rst),
        .wr       (wr),
        .rd       (rd),
        .wr_ack   (wr_ack),
        .rd_ack   (rd_ack),
        .rd_data  (rd_data),
        .pps_in   (pps_in),
        .ext_trig (ext_trig),
        .trig_out (trig_out)
    );

    bind ptp_core ptp_core_sva u_sva (
        .clk      (clk),
        .rst      (rst),
        .wr_req   (wr.req),
        .rd_req   (rd.req),
        .wr_ack   (wr_ack),
        .rd_ack   (rd_ack),
        .trig_out (trig_out),
        .now_ns   (now.nanosecond)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // free running cycle and pulse counters
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (trig_out) begin
            trig_count <= trig_count + 1;
        end
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_word(input int nbits);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr  = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic check(input bit ok, input string what);
        if (!timed_out) begin
            checks++;
            assert (ok) else begin
                $display("ERR %0t: %s", $time, what);
                errors++;
            end
        end
    endtask

    task automatic wait_cycles(input int unsigned n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // one bus request followed by a wait for its ack
    task automatic bus_op(input bit write, input logic [15:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata);
        int unsigned n;
        n     = 0;
        rdata = '0;
        if (!timed_out) begin
            @(posedge clk);
            #2;
            wr = '{write, addr, wdata};
            rd = '{!write, addr};
            @(posedge clk);
            #2;
            wr.req = 1'b0;
            rd.req = 1'b0;
            while (!(wr_ack || rd_ack) && n < ACK_TIMEOUT) begin
                wait_cycles(1);
                n++;
            end
            if (!(wr_ack || rd_ack)) begin
                $display("no ack within %0d cycles for address %0d", ACK_TIMEOUT, addr);
                timed_out = 1'b1;
            end
            rdata = rd_data;
            check(n == 0, $sformatf("ack for address %0d came %0d cycles late", addr, n));
        end
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        logic [31:0] unused_data;
        bus_op(1'b1, addr, data, unused_data);
    endtask

    task automatic read_reg(input logic [15:0] addr, output logic [31:0] data);
        bus_op(1'b0, addr, 32'd0, data);
    endtask

    task automatic take_snap(output logic [31:0] s, output logic [31:0] n);
        write_reg(ADDR_TIMEGET, 32'd1);
        read_reg(ADDR_SNAP_SECOND, s);
        read_reg(ADDR_SNAP_NANOSECOND, n);
    endtask

    task automatic report(input string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - mark);
        mark = errors;
    endtask

    // ------------------------------------------------------------
    // tests
    // ------------------------------------------------------------
    task automatic exercise_registers();
        logic [31:0] data;
        logic [31:0] value;
        logic [31:0] ident [4];
        logic [15:0] regs [10];
        logic [31:0] masks [10];
        ident = '{PRODUCT_ID, VERSION, BUILD_DATE, BUILD_TIME};
        for (int i = 0; i < 4; i++) begin
            read_reg(16'(i + 1), data);
            check(data == ident[i], $sformatf("identity word %0d read %h", i + 1, data));
        end
        // bit 6 set keeps the decoded address above the map
        for (int i = 0; i < 8; i++) begin
            value = rand_word(16);
            read_reg(value[15:0] | 16'h0040, data);
            check(data == UNMAPPED_DATA, $sformatf("unmapped read gave %h", data));
        end
        report("identity and decode");
        regs  = '{ADDR_SCRATCH, ADDR_RTC_MODE, ADDR_SECOND, ADDR_NANOSECOND, ADDR_TIMESET,
                  ADDR_TIMEGET, ADDR_TRIG_SOURCE, ADDR_TRIG_ENABLE, ADDR_TRIG_SECOND,
                  ADDR_TRIG_NS};
        masks = '{32'hFFFF_FFFF, 32'h1, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0, 32'h0, 32'h3,
                  32'h1, 32'hFFFF_FFFF, 32'hFFFF_FFFF};
        for (int i = 0; i < 10; i++) begin
            value = rand_word(32);
            if (regs[i] == ADDR_NANOSECOND) begin
                // a random timeset below may load this into the clock
                value = value % NS_PER_SEC;
            end
            write_reg(regs[i], value);
            read_reg(regs[i], data);
            check(data == (value & masks[i]),
                  $sformatf("address %0d read %h after writing %h", regs[i], data, value));
        end
        write_reg(ADDR_TRIG_ENABLE, 32'd0);
        write_reg(ADDR_RTC_MODE, 32'd0);
        report("register storage");
    endtask

    task automatic load_and_snap_time();
        logic [31:0] sec;
        logic [31:0] ns;
        logic [31:0] s;
        logic [31:0] n;
        logic [31:0] diff;
        int unsigned c_set;
        int unsigned n_cycles;
        int unsigned steps;
        sec = rand_word(31);
        ns  = rand_word(32) % 32'd999_000_000;
        write_reg(ADDR_SECOND, sec);
        write_reg(ADDR_NANOSECOND, ns);
        write_reg(ADDR_TIMESET, 32'd1);
        c_set = cycle_count;
        wait_cycles(rand_word(4));
        write_reg(ADDR_TIMEGET, 32'd1);
        n_cycles = cycle_count - c_set;
        read_reg(ADDR_SNAP_SECOND, s);
        read_reg(ADDR_SNAP_NANOSECOND, n);
        diff  = n - ns;
        steps = diff / NS_STEP;
        check(s == sec, $sformatf("snapshot second %h, loaded %h", s, sec));
        check(diff % NS_STEP == 0 && steps + 2 >= n_cycles && steps <= n_cycles + 2,
              $sformatf("snapshot ns %0d, loaded %0d, %0d bus cycles", n, ns, n_cycles));
        write_reg(ADDR_NANOSECOND, NS_PER_SEC - 32'd20);
        write_reg(ADDR_TIMESET, 32'd1);
        take_snap(s, n);
        check(s == sec + 32'd1, $sformatf("second %h after carry, loaded %h", s, sec));
        report("load and snapshot");
    endtask

    task automatic follow_pps();
        logic [31:0] s1;
        logic [31:0] n1;
        logic [31:0] s2;
        logic [31:0] n2;
        write_reg(ADDR_RTC_MODE, 32'd1);
        take_snap(s1, n1);
        wait_cycles(5);
        take_snap(s2, n2);
        check(s2 == s1 && n2 == n1, $sformatf("time moved in pps mode, %h.%h", s2, n2));
        pps_in = 1'b1;
        wait_cycles(1);
        pps_in = 1'b0;
        take_snap(s2, n2);
        check(s2 == s1 + 32'd1 && n2 == 32'd0, $sformatf("after pps read %h.%h", s2, n2));
        write_reg(ADDR_RTC_MODE, 32'd0);
        report("pps mode");
    endtask

    task automatic drive_trigger_sources();
        logic [31:0] s;
        logic [31:0] n;
        int unsigned base;
        int unsigned waited;
        write_reg(ADDR_TRIG_SOURCE, {30'd0, TRIG_SRC_MCU});
        base = trig_count;
        write_reg(ADDR_TRIG_ENABLE, 32'd1);
        wait_cycles(6);
        check(trig_count - base == 1, $sformatf("%0d software pulses", trig_count - base));
        write_reg(ADDR_TRIG_ENABLE, 32'd0);
        write_reg(ADDR_TRIG_SOURCE, {30'd0, TRIG_SRC_EXT});
        write_reg(ADDR_TRIG_ENABLE, 32'd1);
        base = trig_count;
        repeat (3) begin
            ext_trig = 1'b1;
            wait_cycles(2);
            ext_trig = 1'b0;
            wait_cycles(3);
        end
        check(trig_count - base == 3, $sformatf("%0d pulses for 3 edges", trig_count - base));
        write_reg(ADDR_TRIG_ENABLE, 32'd0);
        write_reg(ADDR_TRIG_SOURCE, {30'd0, TRIG_SRC_RTC});
        take_snap(s, n);
        // ten cycles of bus traffic up to enable, then about twenty more
        n = n + 30 * NS_STEP;
        if (n >= NS_PER_SEC) begin
            n = n - NS_PER_SEC;
            s = s + 32'd1;
        end
        write_reg(ADDR_TRIG_SECOND, s);
        write_reg(ADDR_TRIG_NS, n);
        base = trig_count;
        write_reg(ADDR_TRIG_ENABLE, 32'd1);
        waited = 0;
        while (trig_count == base && waited < 30) begin
            wait_cycles(1);
            waited++;
        end
        check(trig_count != base, "no clock match pulse within 30 cycles");
        wait_cycles(10);
        check(trig_count - base == 1, $sformatf("%0d clock match pulses", trig_count - base));
        write_reg(ADDR_TRIG_ENABLE, 32'd0);
        write_reg(ADDR_TRIG_SOURCE, 32'd2);
        base = trig_count;
        write_reg(ADDR_TRIG_ENABLE, 32'd1);
        ext_trig = 1'b1;
        wait_cycles(2);
        ext_trig = 1'b0;
        wait_cycles(10);
        check(trig_count == base, $sformatf("%0d pulses from code 2", trig_count - base));
        write_reg(ADDR_TRIG_ENABLE, 32'd0);
        report("triggers");
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        rst      = 1'b1;
        wr       = '0;
        rd       = '0;
        pps_in   = 1'b0;
        ext_trig = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        exercise_registers();
        load_and_snap_time();
        follow_pps();
        drive_trigger_sources();
        sva_fails = u_ptp_core.u_sva.wr_ack_fails + u_ptp_core.u_sva.rd_ack_fails
                  + u_ptp_core.u_sva.pulse_fails + u_ptp_core.u_sva.range_fails;
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d, timeout %0d",
                 tests, checks, errors, sva_fails, timed_out);
        if (errors == 0 && sva_fails == 0 && !timed_out) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/ptp_core_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module ptp_core_sva (
    input var logic        clk,
    input var logic        rst,
    input var logic        wr_req,
    input var logic        rd_req,
    input var logic        wr_ack,
    input var logic        rd_ack,
    input var logic        trig_out,
    input var logic [31:0] now_ns
);

    import ptp_pkg::*;

    // failure counts per property
    int unsigned wr_ack_fails = 0;
    int unsigned rd_ack_fails = 0;
    int unsigned pulse_fails  = 0;
    int unsigned range_fails  = 0;

    // ------------------------------------------------------------
    // ack exactly one cycle after req on both buses
    // ------------------------------------------------------------
    wr_ack_timing: assert property (@(posedge clk) disable iff (rst) wr_ack == $past(wr_req))
        else begin
            wr_ack_fails = wr_ack_fails + 1;
            $error("wr_ack does not follow wr.req by one cycle");
        end

    rd_ack_timing: assert property (@(posedge clk) disable iff (rst) rd_ack == $past(rd_req))
        else begin
            rd_ack_fails = rd_ack_fails + 1;
            $error("rd_ack does not follow rd.req by one cycle");
        end

    // trigger output is a single cycle pulse
    trig_single: assert property (@(posedge clk) disable iff (rst) trig_out |=> !trig_out)
        else begin
            pulse_fails = pulse_fails + 1;
            $error("trig_out high for two cycles in a row");
        end

    ns_range: assert property (@(posedge clk) disable iff (rst) now_ns < NS_PER_SEC)
        else begin
            range_fails = range_fails + 1;
            $error("nanosecond count reached one second");
        end

endmodule

`default_nettype wire

/* src/ptp_core.sv */
`timescale 1ns/100ps
`default_nettype none

module ptp_core #(
    parameter int unsigned ADDR_WIDTH = 10,
    parameter int unsigned NS_STEP    = 40
) (
    input  var logic             clk,
    input  var logic             rst,
    input  var ptp_pkg::up_wr_t  wr,
    input  var ptp_pkg::up_rd_t  rd,
    output var logic             wr_ack,
    output var logic             rd_ack,
    output var logic [31:0]      rd_data,
    input  var logic             pps_in,
    input  var logic             ext_trig,
    output var logic             trig_out
);

    import ptp_pkg::*;

    rtc_ctrl_t  rtc_ctrl;
    trig_ctrl_t trig_ctrl;
    ptp_time_t  now;
    ptp_time_t  snap;

    // ------------------------------------------------------------
    // host registers
    // ------------------------------------------------------------
    ptp_regs #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_ptp_regs (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr),
        .rd        (rd),
        .wr_ack    (wr_ack),
        .rd_ack    (rd_ack),
        .rd_data   (rd_data),
        .snap      (snap),
        .rtc_ctrl  (rtc_ctrl),
        .trig_ctrl (trig_ctrl)
    );

    // time of day
    ptp_rtc #(
        .NS_STEP (NS_STEP)
    ) u_ptp_rtc (
        .clk      (clk),
        .rst      (rst),
        .pps_in   (pps_in),
        .rtc_ctrl (rtc_ctrl),
        .now      (now),
        .snap     (snap)
    );

    // trigger pulse out
    ptp_trigger u_ptp_trigger (
        .clk       (clk),
        .rst       (rst),
        .ext_trig  (ext_trig),
        .trig_ctrl (trig_ctrl),
        .now       (now),
        .trig_out  (trig_out)
    );

endmodule

`default_nettype wire

/* src/ptp_trigger.sv */
`timescale 1ns/100ps
`default_nettype none

module ptp_trigger (
    input  var logic                 clk,
    input  var logic                 rst,
    input  var logic                 ext_trig,
    input  var ptp_pkg::trig_ctrl_t  trig_ctrl,
    input  var ptp_pkg::ptp_time_t   now,
    output var logic                 trig_out
);

    import ptp_pkg::*;

    logic      enable_q;
    logic      ext_q;
    ptp_time_t match_q;
    logic      armed;

    logic enable_rise;
    logic ext_rise;
    logic match_change;
    logic reached;
    logic fire;

    assign enable_rise  = trig_ctrl.enable & ~enable_q;
    assign ext_rise     = ext_trig & ~ext_q;
    assign match_change = trig_ctrl.match_time != match_q;
    // second sits above nanosecond, so one wide compare orders the time
    assign reached      = now >= trig_ctrl.match_time;

    always_comb begin
        case (trig_ctrl.source)
            TRIG_SRC_MCU: fire = enable_rise;
            TRIG_SRC_EXT: fire = trig_ctrl.enable & ext_rise;
            TRIG_SRC_RTC: fire = trig_ctrl.enable & armed & reached;
            default:      fire = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            enable_q <= 1'b0;
            ext_q    <= 1'b0;
            match_q  <= '0;
            armed    <= 1'b0;
            trig_out <= 1'b0;
        end else begin
            enable_q <= trig_ctrl.enable;
            ext_q    <= ext_trig;
            match_q  <= trig_ctrl.match_time;
            trig_out <= fire;

            // one shot compare that disarms in the cycle it fires
            if (!trig_ctrl.enable) begin
                armed <= 1'b0;
            end else if (armed && reached) begin
                armed <= 1'b0;
            end else if (enable_rise || match_change) begin
                armed <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/ptp_rtc.sv */
`timescale 1ns/100ps
`default_nettype none

module ptp_rtc #(
    parameter int unsigned NS_STEP = 40
) (
    input  var logic                clk,
    input  var logic                rst,
    input  var logic                pps_in,
    input  var ptp_pkg::rtc_ctrl_t  rtc_ctrl,
    output var ptp_pkg::ptp_time_t  now,
    output var ptp_pkg::ptp_time_t  snap
);

    import ptp_pkg::*;

    logic [32:0] ns_sum;
    logic [32:0] ns_wrap;
    logic [31:0] ns_next;
    logic        sec_carry;

    // ------------------------------------------------------------
    // free running step with carry into the seconds
    // ------------------------------------------------------------
    always_comb begin
        ns_sum  = {1'b0, now.nanosecond} + 33'(NS_STEP);
        ns_wrap = ns_sum - {1'b0, NS_PER_SEC};
        if (ns_sum >= {1'b0, NS_PER_SEC}) begin
            ns_next   = ns_wrap[31:0];
            sec_carry = 1'b1;
        end else begin
            ns_next   = ns_sum[31:0];
            sec_carry = 1'b0;
        end
    end

    // load beats pps and counting
    always_ff @(posedge clk) begin
        if (rst) begin
            now <= '0;
        end else if (rtc_ctrl.timeset) begin
            now <= rtc_ctrl.load_time;
        end else if (rtc_ctrl.pps_mode) begin
            // pps mode holds the time until the next pulse
            if (pps_in) begin
                now.second     <= now.second + 32'd1;
                now.nanosecond <= '0;
            end
        end else begin
            now.second     <= now.second + {31'd0, sec_carry};
            now.nanosecond <= ns_next;
        end
    end

    // ------------------------------------------------------------
    // snapshot for the host
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            snap <= '0;
        end else if (rtc_ctrl.timeget) begin
            snap <= now;
        end
    end

endmodule

`default_nettype wire

/* src/ptp_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module ptp_regs #(
    parameter int unsigned ADDR_WIDTH = 10
) (
    input  var logic                 clk,
    input  var logic                 rst,
    input  var ptp_pkg::up_wr_t      wr,
    input  var ptp_pkg::up_rd_t      rd,
    output var logic                 wr_ack,
    output var logic                 rd_ack,
    output var logic [31:0]          rd_data,
    input  var ptp_pkg::ptp_time_t   snap,
    output var ptp_pkg::rtc_ctrl_t   rtc_ctrl,
    output var ptp_pkg::trig_ctrl_t  trig_ctrl
);

    import ptp_pkg::*;

    `include "ptp_version.svh"

    // address map
    //   1..4    identity words, read only
    //   8       scratch
    //   16      pps mode, bit 0
    //   17, 18  load time second and nanosecond
    //   19, 20  timeset and timeget strobes, read as zero
    //   21, 22  snapshot second and nanosecond, read only
    //   32      trigger enable, bit 0
    //   33      trigger source, bits 1:0
    //   34, 35  trigger match second and nanosecond

    // only the low ADDR_WIDTH bits of the bus address take part in decode
    localparam logic [15:0] ADDR_MASK = 16'((32'd1 << ADDR_WIDTH) - 32'd1);

    logic [15:0] wr_addr;
    logic [15:0] rd_addr;
    logic [31:0] scratch;

    assign wr_addr = wr.addr & ADDR_MASK;
    assign rd_addr = rd.addr & ADDR_MASK;

    // ------------------------------------------------------------
    // write side
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            scratch   <= '0;
            rtc_ctrl  <= '0;
            trig_ctrl <= '0;
        end else begin
            // strobes live for one cycle only
            rtc_ctrl.timeset <= 1'b0;
            rtc_ctrl.timeget <= 1'b0;

            if (wr.req) begin
                case (wr_addr)
                    ADDR_SCRATCH:     scratch                         <= wr.data;
                    ADDR_RTC_MODE:    rtc_ctrl.pps_mode               <= wr.data[0];
                    ADDR_SECOND:      rtc_ctrl.load_time.second       <= wr.data;
                    ADDR_NANOSECOND:  rtc_ctrl.load_time.nanosecond   <= wr.data;
                    ADDR_TIMESET:     rtc_ctrl.timeset                <= wr.data[0];
                    ADDR_TIMEGET:     rtc_ctrl.timeget                <= wr.data[0];
                    ADDR_TRIG_ENABLE: trig_ctrl.enable                <= wr.data[0];
                    ADDR_TRIG_SOURCE: trig_ctrl.source                <= wr.data[1:0];
                    ADDR_TRIG_SECOND: trig_ctrl.match_time.second     <= wr.data;
                    ADDR_TRIG_NS:     trig_ctrl.match_time.nanosecond <= wr.data;
                    default: ;
                endcase
            end
        end
    end

    // one cycle write response
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ack <= 1'b0;
        end else begin
            wr_ack <= wr.req;
        end
    end

    // ------------------------------------------------------------
    // read side
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rd.req) begin
            case (rd_addr)
                ADDR_PRODUCT_ID:      rd_data <= PRODUCT_ID;
                ADDR_VERSION:         rd_data <= VERSION;
                ADDR_BUILD_DATE:      rd_data <= BUILD_DATE;
                ADDR_BUILD_TIME:      rd_data <= BUILD_TIME;
                ADDR_SCRATCH:         rd_data <= scratch;
                ADDR_RTC_MODE:        rd_data <= {31'd0, rtc_ctrl.pps_mode};
                ADDR_SECOND:          rd_data <= rtc_ctrl.load_time.second;
                ADDR_NANOSECOND:      rd_data <= rtc_ctrl.load_time.nanosecond;
                ADDR_TIMESET:         rd_data <= 32'd0;
                ADDR_TIMEGET:         rd_data <= 32'd0;
                ADDR_SNAP_SECOND:     rd_data <= snap.second;
                ADDR_SNAP_NANOSECOND: rd_data <= snap.nanosecond;
                ADDR_TRIG_ENABLE:     rd_data <= {31'd0, trig_ctrl.enable};
                ADDR_TRIG_SOURCE:     rd_data <= {30'd0, trig_ctrl.source};
                ADDR_TRIG_SECOND:     rd_data <= trig_ctrl.match_time.second;
                ADDR_TRIG_NS:         rd_data <= trig_ctrl.match_time.nanosecond;
                default:              rd_data <= UNMAPPED_DATA;
            endcase
        end
    end

    // rd_data and rd_ack line up in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ack <= 1'b0;
        end else begin
            rd_ack <= rd.req;
        end
    end

endmodule

`default_nettype wire

/* src/ptp_pkg.sv */
`default_nettype none

package ptp_pkg;

    // time of day as seen by the host and the trigger comparator
    typedef struct packed {
        logic [31:0] second;
        logic [31:0] nanosecond;
    } ptp_time_t;

    // host bus with one request per cycle and the ack one cycle later
    typedef struct packed {
        logic        req;
        logic [15:0] addr;
        logic [31:0] data;
    } up_wr_t;

    typedef struct packed {
        logic        req;
        logic [15:0] addr;
    } up_rd_t;

    typedef struct packed {
        logic      pps_mode;
        ptp_time_t load_time;
        logic      timeset;
        logic      timeget;
    } rtc_ctrl_t;

    typedef struct packed {
        logic      enable;
        logic [1:0] source;
        ptp_time_t match_time;
    } trig_ctrl_t;

    // trigger source select where code 2 is reserved and never fires
    localparam logic [1:0] TRIG_SRC_MCU = 2'd0;
    localparam logic [1:0] TRIG_SRC_EXT = 2'd1;
    localparam logic [1:0] TRIG_SRC_RTC = 2'd3;

    localparam logic [31:0] NS_PER_SEC = 32'd1_000_000_000;

    // ------------------------------------------------------------
    // register map
    // ------------------------------------------------------------
    localparam logic [15:0] ADDR_PRODUCT_ID      = 16'd1;
    localparam logic [15:0] ADDR_VERSION         = 16'd2;
    localparam logic [15:0] ADDR_BUILD_DATE      = 16'd3;
    localparam logic [15:0] ADDR_BUILD_TIME      = 16'd4;
    localparam logic [15:0] ADDR_SCRATCH         = 16'd8;
    localparam logic [15:0] ADDR_RTC_MODE        = 16'd16;
    localparam logic [15:0] ADDR_SECOND          = 16'd17;
    localparam logic [15:0] ADDR_NANOSECOND      = 16'd18;
    localparam logic [15:0] ADDR_TIMESET         = 16'd19;
    localparam logic [15:0] ADDR_TIMEGET         = 16'd20;
    localparam logic [15:0] ADDR_SNAP_SECOND     = 16'd21;
    localparam logic [15:0] ADDR_SNAP_NANOSECOND = 16'd22;
    localparam logic [15:0] ADDR_TRIG_ENABLE     = 16'd32;
    localparam logic [15:0] ADDR_TRIG_SOURCE     = 16'd33;
    localparam logic [15:0] ADDR_TRIG_SECOND     = 16'd34;
    localparam logic [15:0] ADDR_TRIG_NS         = 16'd35;

    localparam logic [31:0] UNMAPPED_DATA = 32'hDEADBEEF;

endpackage

`default_nettype wire

/* src/ptp_version.svh */
// identity words returned at addresses 1 to 4
localparam logic [31:0] PRODUCT_ID = 32'h0000_1588;
localparam logic [31:0] VERSION    = 32'h0001_0002;

// build stamp words stay at zero in development builds
localparam logic [31:0] BUILD_DATE = 32'h0000_0000;
localparam logic [31:0] BUILD_TIME = 32'h0000_0000;
